// File: design/alu_settings.svh
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Datapath width in bits
// The opcode table and the instruction layout assume 8
`define ALU_DATA_W 8

// Register file depth, gives 3-bit indices
`define ALU_REG_COUNT 8

// Instruction word width
// Register form is 1+4+3+3+3 plus 2 pad bits
// Immediate form is 1+4+3 plus an 8-bit immediate
`define ALU_INSTR_W 16

`endif

// File: design/alu_pkg.sv
`include "alu_settings.svh"

package alu_pkg;

  typedef logic [`ALU_DATA_W-1:0] data_t;
  typedef logic [$clog2(`ALU_REG_COUNT)-1:0] reg_idx_t;

  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    AND = 4'd2,
    OR  = 4'd3,
    XOR = 4'd4,
    INC = 4'd5,
    DEC = 4'd6,
    SHL = 4'd7,
    SHR = 4'd8,
    ROL = 4'd9,
    ROR = 4'd10,
    SLT = 4'd11,
    ADC = 4'd12,  // Uses stored carry
    SBC = 4'd13   // 14 and 15 are invalid
  } alu_op_e;

  typedef struct packed {
    logic c;
    logic v;
    logic s;
    logic z;
  } flags_t;

  typedef struct packed {
    logic                   imm_sel;  // 0 here
    alu_op_e                op;
    reg_idx_t               rd;
    reg_idx_t               ra;
    reg_idx_t               rb;
    logic [`ALU_INSTR_W-15:0] pad;
  } instr_reg_t;

  typedef struct packed {
    logic     imm_sel;  // 1 here
    alu_op_e  op;
    reg_idx_t rd;       // Also operand A
    data_t    imm;      // Operand B
  } instr_imm_t;

  typedef union packed {
    instr_reg_t r;
    instr_imm_t i;
  } instr_t;

  typedef struct packed {
    logic     valid;
    alu_op_e  op;
    reg_idx_t rd;
    reg_idx_t ra;
    reg_idx_t rb;
    logic     use_imm;
    data_t    imm;
  } dec_t;

  typedef struct packed {
    logic     valid;
    logic     write;  // Register write enable
    reg_idx_t rd;
    data_t    result;
    flags_t   flags;
  } exe_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    data_t    result;
    flags_t   flags;
  } wb_t;

endpackage

// File: design/op_decode.sv
`timescale 1ns/1ps

module op_decode (
  input  logic            clk,
  input  logic            reset,
  input  logic            instr_valid,
  input  alu_pkg::instr_t instr,
  output alu_pkg::dec_t   dec
);

  alu_pkg::dec_t dec_next;

  always_comb begin
    dec_next         = '0;
    dec_next.valid   = instr_valid;
    dec_next.use_imm = instr.r.imm_sel;
    dec_next.op      = instr.r.op;  // Shared by both forms
    dec_next.rd      = instr.r.rd;

    if (instr.i.imm_sel) begin
      // Immediate form reads rd as operand A
      dec_next.ra  = instr.i.rd;
      dec_next.rb  = '0;  // Unused, B comes from imm
      dec_next.imm = instr.i.imm;
    end else begin
      dec_next.ra  = instr.r.ra;
      dec_next.rb  = instr.r.rb;
      dec_next.imm = '0;
    end
  end

  // Payload loads every cycle, only valid is cleared
  always_ff @(posedge clk) begin
    dec <= dec_next;
    if (reset) begin
      dec.valid <= 1'b0;
    end
  end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps
`include "alu_settings.svh"

module reg_file (
  input  logic              clk,
  input  logic              reset,
  input  alu_pkg::reg_idx_t ra_addr,
  input  alu_pkg::reg_idx_t rb_addr,
  output alu_pkg::data_t    ra_data,
  output alu_pkg::data_t    rb_data,
  input  logic              we,
  input  alu_pkg::reg_idx_t waddr,
  input  alu_pkg::data_t    wdata
);

  alu_pkg::data_t regs [`ALU_REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `ALU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // Async read, no write-through needed
  assign ra_data = regs[ra_addr];
  assign rb_data = regs[rb_addr];

endmodule

// File: design/alu_core.sv
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_core (
  input  logic              clk,
  input  logic              reset,
  input  alu_pkg::dec_t     dec,
  input  logic              carry,
  output alu_pkg::reg_idx_t ra_addr,
  output alu_pkg::reg_idx_t rb_addr,
  input  alu_pkg::data_t    ra_data,
  input  alu_pkg::data_t    rb_data,
  output alu_pkg::exe_t     exe
);

  alu_pkg::data_t    a;
  alu_pkg::data_t    b;
  alu_pkg::data_t    add_b;
  logic              add_ci;
  logic              cin;
  logic [`ALU_DATA_W:0] sum;
  logic              add_v;
  logic              op_ok;
  alu_pkg::data_t    res;
  alu_pkg::flags_t   fl;
  alu_pkg::exe_t     exe_next;

  assign ra_addr = dec.ra;
  assign rb_addr = dec.rb;

  // Forward from the instruction one ahead
  always_comb begin
    a = ra_data;
    if (exe.write && exe.rd == dec.ra) begin
      a = exe.result;
    end

    b = rb_data;
    if (exe.write && exe.rd == dec.rb) begin
      b = exe.result;
    end
    if (dec.use_imm) begin
      b = dec.imm;
    end

    cin = exe.valid ? exe.flags.c : carry;  // Carry not yet committed
  end

  // Shared adder for ADD, ADC, SUB and SBC
  always_comb begin
    add_b  = b;
    add_ci = 1'b0;
    case (dec.op)
      alu_pkg::ADC: add_ci = cin;
      alu_pkg::SUB: begin
        add_b  = ~b;
        add_ci = 1'b1;
      end
      alu_pkg::SBC: begin
        add_b  = ~b;
        add_ci = cin;
      end
      default: add_ci = 1'b0;
    endcase
  end

  assign sum = {1'b0, a} + {1'b0, add_b} + add_ci;

  // Same sign in, different sign out, covers SUB through ~B
  assign add_v = (a[`ALU_DATA_W-1] == add_b[`ALU_DATA_W-1]) &&
                 (sum[`ALU_DATA_W-1] != a[`ALU_DATA_W-1]);

  always_comb begin
    res   = '0;
    fl    = '0;
    op_ok = 1'b1;
    case (dec.op)
      alu_pkg::ADD, alu_pkg::ADC, alu_pkg::SUB, alu_pkg::SBC: begin
        res  = sum[`ALU_DATA_W-1:0];
        fl.c = sum[`ALU_DATA_W];  // 1 means no borrow on subtract
        fl.v = add_v;
      end
      alu_pkg::AND: res = a & b;
      alu_pkg::OR:  res = a | b;
      alu_pkg::XOR: res = a ^ b;
      alu_pkg::INC: begin
        res  = a + 1'b1;
        fl.c = (a == '1);
        fl.v = a[`ALU_DATA_W-1] && !res[`ALU_DATA_W-1];
      end
      alu_pkg::DEC: begin
        res  = a - 1'b1;
        fl.c = (a == '0);
        fl.v = !a[`ALU_DATA_W-1] && res[`ALU_DATA_W-1];
      end
      alu_pkg::SHL: begin
        res  = b << 1;
        fl.c = b[`ALU_DATA_W-1];
        fl.v = b[`ALU_DATA_W-1] != res[`ALU_DATA_W-1];
      end
      alu_pkg::SHR: begin
        res  = b >> 1;
        fl.c = b[0];
      end
      alu_pkg::ROL: begin
        res  = {b[`ALU_DATA_W-2:0], b[`ALU_DATA_W-1]};
        fl.c = b[`ALU_DATA_W-1];
        fl.v = b[`ALU_DATA_W-1] != res[`ALU_DATA_W-1];
      end
      alu_pkg::ROR: begin
        res  = {b[0], b[`ALU_DATA_W-1:1]};
        fl.c = b[0];
        fl.v = b[0] != res[0];
      end
      alu_pkg::SLT: res[0] = (a < b);  // Unsigned compare
      default: op_ok = 1'b0;            // Result and all flags stay 0
    endcase

    if (op_ok) begin
      fl.s = res[`ALU_DATA_W-1];
      fl.z = (res == '0);
    end
  end

  always_comb begin
    exe_next.valid  = dec.valid;
    exe_next.write  = dec.valid && op_ok;
    exe_next.rd     = dec.rd;
    exe_next.result = res;
    exe_next.flags  = fl;
  end

  always_ff @(posedge clk) begin
    exe <= exe_next;
    if (reset) begin
      exe.valid <= 1'b0;
      exe.write <= 1'b0;
    end
  end

endmodule

// File: design/flag_writeback.sv
`timescale 1ns/1ps

module flag_writeback (
  input  logic              clk,
  input  logic              reset,
  input  alu_pkg::exe_t     exe,
  output logic              we,
  output alu_pkg::reg_idx_t waddr,
  output alu_pkg::data_t    wdata,
  output logic              carry,
  output alu_pkg::wb_t      wb
);

  alu_pkg::flags_t   flags_q;
  logic              wb_valid_q;
  alu_pkg::reg_idx_t wb_rd_q;
  alu_pkg::data_t    wb_result_q;

  // Commit lands on the same edge as wb
  assign we    = exe.valid && exe.write;
  assign waddr = exe.rd;
  assign wdata = exe.result;

  always_ff @(posedge clk) begin
    if (reset) begin
      flags_q <= '0;
    end else if (exe.valid) begin
      flags_q <= exe.flags;  // Invalid ops clear flags too
    end
  end

  assign carry = flags_q.c;

  always_ff @(posedge clk) begin
    wb_rd_q     <= exe.rd;
    wb_result_q <= exe.result;
    if (reset) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= exe.valid;
    end
  end

  // Flag register already holds this op's flags when wb is valid
  always_comb begin
    wb.valid  = wb_valid_q;
    wb.rd     = wb_rd_q;
    wb.result = wb_result_q;
    wb.flags  = flags_q;
  end

endmodule

// File: design/alu_pipe_top.sv
`timescale 1ns/1ps

module alu_pipe_top (
  input  logic            clk,
  input  logic            reset,
  input  logic            instr_valid,
  input  alu_pkg::instr_t instr,
  output alu_pkg::wb_t    wb
);

  alu_pkg::dec_t     dec;
  alu_pkg::exe_t     exe;
  alu_pkg::reg_idx_t ra_addr;
  alu_pkg::reg_idx_t rb_addr;
  alu_pkg::data_t    ra_data;
  alu_pkg::data_t    rb_data;
  logic              we;
  alu_pkg::reg_idx_t waddr;
  alu_pkg::data_t    wdata;
  logic              carry;

  op_decode op_decode_i (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .dec         (dec)
  );

  reg_file reg_file_i (
    .clk     (clk),
    .reset   (reset),
    .ra_addr (ra_addr),
    .rb_addr (rb_addr),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .we      (we),
    .waddr   (waddr),
    .wdata   (wdata)
  );

  alu_core alu_core_i (
    .clk     (clk),
    .reset   (reset),
    .dec     (dec),
    .carry   (carry),
    .ra_addr (ra_addr),
    .rb_addr (rb_addr),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .exe     (exe)
  );

  flag_writeback flag_writeback_i (
    .clk   (clk),
    .reset (reset),
    .exe   (exe),
    .we    (we),
    .waddr (waddr),
    .wdata (wdata),
    .carry (carry),  // Stored carry back to stage 2
    .wb    (wb)
  );

endmodule

// File: bench/alu_pipe_tb.sv
`timescale 1ns/1ps

module alu_pipe_tb;

  localparam int num_random = 2000;
  localparam int num_slots  = 2 * num_random + 400;  // Issue cycles, idles included

  logic            clk;
  logic            reset;
  logic            instr_valid;
  alu_pkg::instr_t instr;
  alu_pkg::wb_t    wb;

  logic [7:0]      model_regs [8];
  logic            model_carry;
  alu_pkg::wb_t    exp_q [$];  // One entry per cycle, idle or not
  logic [15:0]     lfsr;

  alu_pipe_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb          (wb)
  );

  always #5 clk = ~clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // Expected writeback for one instruction
  function automatic alu_pkg::wb_t model_exec(input logic [3:0] op, input logic [7:0] a,
                                               input logic [7:0] b, input logic cin,
                                               input logic [2:0] rd);
    alu_pkg::wb_t e;
    logic [8:0]   wide;
    e       = '0;
    e.valid = 1'b1;
    e.rd    = rd;
    case (op)
      alu_pkg::ADD, alu_pkg::ADC: begin
        wide      = {1'b0, a} + {1'b0, b} + ((op == alu_pkg::ADC) ? {8'd0, cin} : 9'd0);
        e.result  = wide[7:0];
        e.flags.c = wide[8];
        e.flags.v = (a[7] == b[7]) && (wide[7] != a[7]);
      end
      alu_pkg::SUB, alu_pkg::SBC: begin
        wide      = {1'b0, a} + {1'b0, ~b} + ((op == alu_pkg::SUB) ? 9'd1 : {8'd0, cin});
        e.result  = wide[7:0];
        e.flags.c = wide[8];  // Set when no borrow
        e.flags.v = (a[7] != b[7]) && (wide[7] != a[7]);
      end
      alu_pkg::AND: e.result = a & b;
      alu_pkg::OR:  e.result = a | b;
      alu_pkg::XOR: e.result = a ^ b;
      alu_pkg::INC: begin
        e.result  = a + 8'd1;
        e.flags.c = (a == 8'hFF);
        e.flags.v = a[7] && !e.result[7];
      end
      alu_pkg::DEC: begin
        e.result  = a - 8'd1;
        e.flags.c = (a == 8'h00);
        e.flags.v = !a[7] && e.result[7];
      end
      alu_pkg::SHL, alu_pkg::ROL: begin
        e.result  = {b[6:0], (op == alu_pkg::ROL) ? b[7] : 1'b0};
        e.flags.c = b[7];
        e.flags.v = b[7] != e.result[7];
      end
      alu_pkg::SHR: begin
        e.result  = {1'b0, b[7:1]};
        e.flags.c = b[0];
      end
      alu_pkg::ROR: begin
        e.result  = {b[0], b[7:1]};
        e.flags.c = b[0];
        e.flags.v = b[0] != e.result[0];
      end
      alu_pkg::SLT: e.result = (a < b) ? 8'd1 : 8'd0;
      default: return e;  // Codes 14 and 15 give all zero
    endcase
    e.flags.s = e.result[7];
    e.flags.z = (e.result == 8'h00);
    return e;
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [7:0] got, input logic [7:0] exp);
    report_fail($sformatf("Error: %s is %h, expected %h", name, got, exp));
  endtask

  // Drives one cycle and updates the model at issue
  task automatic issue(input logic valid, input alu_pkg::instr_t ins);
    alu_pkg::wb_t e;
    logic [7:0]   a;
    logic [7:0]   b;
    @(posedge clk);
    #1;
    instr_valid = valid;
    instr       = ins;
    e           = '0;
    if (valid) begin
      a = ins.i.imm_sel ? model_regs[ins.i.rd] : model_regs[ins.r.ra];
      b = ins.i.imm_sel ? ins.i.imm : model_regs[ins.r.rb];
      e = model_exec(ins.r.op, a, b, model_carry, ins.r.rd);
      if (ins.r.op <= alu_pkg::SBC) begin
        model_regs[ins.r.rd] = e.result;
      end
      model_carry = e.flags.c;
    end
    exp_q.push_back(e);
  endtask

  task automatic reg_op(input logic [3:0] op, input logic [2:0] rd, ra, rb);
    alu_pkg::instr_t ins;
    ins      = '0;
    ins.r.op = alu_pkg::alu_op_e'(op);
    ins.r.rd = rd;
    ins.r.ra = ra;
    ins.r.rb = rb;
    issue(1'b1, ins);
  endtask

  task automatic imm_op(input logic [3:0] op, input logic [2:0] rd, input logic [7:0] imm);
    alu_pkg::instr_t ins;
    ins           = '0;
    ins.i.imm_sel = 1'b1;
    ins.i.op      = alu_pkg::alu_op_e'(op);
    ins.i.rd      = rd;
    ins.i.imm     = imm;
    issue(1'b1, ins);
  endtask

  task automatic load_reg(input logic [2:0] rd, input logic [7:0] val);
    imm_op(alu_pkg::AND, rd, 8'h00);
    imm_op(alu_pkg::OR, rd, val);
  endtask

  // Sampled mid-cycle, away from the drive edge
  always @(negedge clk) begin : check_wb
    alu_pkg::wb_t e;
    if (!reset) begin
      if (exp_q.size() == 4) begin
        e = exp_q.pop_front();
        assert (wb.valid == e.valid)
          else value_error("wb.valid", {7'd0, wb.valid}, {7'd0, e.valid});
        if (e.valid) begin
          assert (wb.rd == e.rd) else value_error("wb.rd", {5'd0, wb.rd}, {5'd0, e.rd});
          assert (wb.result == e.result) else value_error("wb.result", wb.result, e.result);
          assert (wb.flags == e.flags)
            else value_error("wb.flags", {4'd0, wb.flags}, {4'd0, e.flags});
        end
      end else begin
        assert (wb.valid == 1'b0) else value_error("wb.valid", {7'd0, wb.valid}, 8'h00);
      end
    end
  end

  initial begin
    #((num_slots + 50) * 10 * 2);
    report_fail("Timeout: the run did not complete in time");
  end

  initial begin
    int         prev;
    int         d;
    logic [3:0] op;
    logic [2:0] rd;
    logic [2:0] ra;
    logic [2:0] rb;
    logic [7:0] imm;
    clk         = 1'b0;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    model_carry = 1'b0;
    lfsr        = 16'd27146;
    for (int r = 0; r < 8; r++) begin
      model_regs[r] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    // Latency and idle gaps
    repeat (3) issue(1'b0, '0);
    imm_op(alu_pkg::OR, 3'd1, 8'h11);
    repeat (4) issue(1'b0, '0);
    imm_op(alu_pkg::ADD, 3'd1, 8'h22);
    imm_op(alu_pkg::XOR, 3'd2, 8'h33);
    repeat (2) issue(1'b0, '0);

    // Edge operands against every opcode
    load_reg(3'd1, 8'h7F);
    load_reg(3'd2, 8'h80);
    load_reg(3'd3, 8'hFF);
    load_reg(3'd4, 8'h00);
    load_reg(3'd5, 8'h01);
    for (int o = 0; o < 14; o++) begin
      for (int k = 1; k <= 5; k++) begin
        reg_op(o[3:0], 3'd6, k[2:0], 3'd5);
        reg_op(o[3:0], 3'd6, k[2:0], k[2:0]);  // SLT of equal values
      end
    end

    // Dependent chains
    load_reg(3'd1, 8'h3C);
    prev = 1;
    for (int i = 0; i < 28; i++) begin
      d = (prev % 7) + 1;
      reg_op(4'(i % 14), d[2:0], prev[2:0], prev[2:0]);
      prev = d;
    end
    reg_op(alu_pkg::ADD, 3'd2, 3'd1, 3'd1);
    reg_op(alu_pkg::OR, 3'd3, 3'd4, 3'd4);
    reg_op(alu_pkg::SUB, 3'd4, 3'd2, 3'd1);  // r2 is two ahead
    repeat (4) imm_op(alu_pkg::ADD, 3'd5, 8'h61);

    // Carry into ADC and SBC, forwarded and from the flag register
    for (int c = 0; c < 2; c++) begin
      load_reg(3'd1, 8'hFF);
      imm_op(alu_pkg::ADD, 3'd1, c[7:0]);
      imm_op(alu_pkg::ADC, 3'd2, 8'h10);
      load_reg(3'd1, 8'hFF);
      imm_op(alu_pkg::ADD, 3'd1, c[7:0]);
      imm_op(alu_pkg::SBC, 3'd3, 8'h10);
      load_reg(3'd1, 8'hFF);
      imm_op(alu_pkg::ADD, 3'd1, c[7:0]);
      issue(1'b0, '0);
      imm_op(alu_pkg::ADC, 3'd2, 8'h20);
    end

    // Invalid opcodes
    load_reg(3'd3, 8'h5A);
    load_reg(3'd1, 8'hFF);
    imm_op(alu_pkg::ADD, 3'd1, 8'h01);
    imm_op(4'd14, 3'd3, 8'hA5);
    imm_op(alu_pkg::ADC, 3'd2, 8'h00);
    load_reg(3'd1, 8'hFF);
    imm_op(alu_pkg::ADD, 3'd1, 8'h01);
    reg_op(4'd15, 3'd3, 3'd3, 3'd3);
    issue(1'b0, '0);
    imm_op(alu_pkg::ADC, 3'd2, 8'h00);
    imm_op(alu_pkg::OR, 3'd3, 8'h00);  // Still 5A

    // Random mix of both forms
    for (int n = 0; n < num_random; n++) begin
      if (rand_bits(2) == 8'd0) begin
        issue(1'b0, '0);
      end
      op  = 4'(rand_bits(4));
      rd  = 3'(rand_bits(3));
      ra  = 3'(rand_bits(3));
      rb  = 3'(rand_bits(3));
      imm = rand_bits(8);
      if (rand_bits(1) == 8'd1) begin
        imm_op(op, rd, imm);
      end else begin
        reg_op(op, rd, ra, rb);
      end
    end

    repeat (4) issue(1'b0, '0);
    @(negedge clk);
    #1;
    $display("test passed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+design
design/alu_pkg.sv
design/op_decode.sv
design/reg_file.sv
design/alu_core.sv
design/flag_writeback.sv
design/alu_pipe_top.sv
bench/alu_pipe_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# A nonzero exit status means the run failed.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module alu_pipe_tb \
  -f verilog.f \
  -o alu_pipe_sim

./obj_dir/alu_pipe_sim
